// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_icache \
	-Mdir obj_dir -o sim_icache -f vlog.f &&
	./obj_dir/sim_icache | tee /dev/stderr | grep -q "^Result: PASSED$" &&
	echo "run.sh: simulation passed" ||
	{ echo "run.sh: simulation failed"; exit 1; }

// ==== source/icache_ctrl.sv ====
`timescale 1ns/10ps

module icache_ctrl (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input icache_pkg::addr_t fetch_addr,
	output logic fetch_ack,
	input logic flush,
	output logic mem_req,
	output icache_pkg::addr_t mem_addr,
	input logic mem_ack,
	input icache_pkg::line_t mem_line,
	output icache_pkg::word_sel_t word_sel,
	output logic refill_bypass,
	output logic load_inst,
	way_bus_if.ctrl ports[icache_pkg::ways]
);
	import icache_pkg::*;

	ctrl_state_t state;
	addr_t addr_q;
	way_mask_t victim;
	way_mask_t hits;
	way_mask_t fills;
	logic fill_now;
	logic any_hit;
	logic flush_now;

	// The refill line is only valid while mem_ack is high.
	assign fill_now = (state == refill) && mem_ack;
	assign flush_now = (state == idle) && flush;
	assign any_hit = |hits;

	assign mem_addr = {addr_q[31:offset_bits], {offset_bits{1'b0}}};
	assign word_sel = addr_q[offset_bits-1 -: word_sel_bits];

	// A miss takes its word straight from mem_line. On a hit the word is taken from
	// the way in the first cycle of respond.
	assign refill_bypass = (state == refill);
	assign load_inst = fill_now || ((state == respond) && !fetch_ack);

	for (genvar i = 0; i < ways; i++) begin : g_port
		assign fills[i] = fill_now && victim[i];
		assign ports[i].index = addr_q[offset_bits +: index_bits];
		assign ports[i].tag = addr_q[31 -: tag_bits];
		assign ports[i].fill = fills[i];
		assign ports[i].fill_line = mem_line;
		assign ports[i].invalidate = flush_now;
		assign hits[i] = ports[i].hit;
	end

	always_ff @(posedge clk) begin
		if ((state == idle) && fetch_req && !flush) begin
			addr_q <= fetch_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			fetch_ack <= 1'b0;
			mem_req <= 1'b0;
			victim <= {{(ways-1){1'b0}}, 1'b1};
		end else begin
			case (state)
				idle: begin
					// Flush wins over a fetch that arrives in the same cycle.
					if (fetch_req && !flush) begin
						state <= lookup;
					end
				end
				lookup: begin
					if (any_hit) begin
						state <= respond;
					end else begin
						mem_req <= 1'b1;
						state <= refill;
					end
				end
				refill: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						victim <= {victim[ways-2:0], victim[ways-1]}; // Rotate after each fill.
						state <= refill_drop;
					end
				end
				refill_drop: begin
					// Wait for the memory to finish its side of the handshake.
					if (!mem_ack) begin
						fetch_ack <= 1'b1;
						state <= respond;
					end
				end
				respond: begin
					if (!fetch_ack) begin
						fetch_ack <= 1'b1;
					end else if (!fetch_req) begin
						fetch_ack <= 1'b0;
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// A line lives in one way only, so a lookup never matches twice.
	a_one_hit: assert property (@(posedge clk) disable iff (rst)
		(state == lookup) |-> $onehot0(hits))
		else $error("more than one way hit: %h", hits);

	a_mem_addr_stable: assert property (@(posedge clk) disable iff (rst)
		mem_req |=> !mem_req || $stable(mem_addr))
		else $error("mem_addr changed while mem_req was high");

	a_one_fill: assert property (@(posedge clk) disable iff (rst)
		$onehot0(fills))
		else $error("fill raised in more than one way: %h", fills);

endmodule

// ==== source/icache_pkg.sv ====
package icache_pkg;

	// Cache geometry.
	localparam int ways = 4;
	localparam int sets = 64;
	localparam int line_bytes = 16;
	localparam int word_bytes = 4;

	localparam int offset_bits = $clog2(line_bytes); // Byte offset within a line.
	localparam int index_bits = $clog2(sets);
	localparam int tag_bits = 32 - index_bits - offset_bits;
	localparam int word_sel_bits = $clog2(line_bytes / word_bytes);

	typedef logic [31:0] addr_t;
	typedef logic [tag_bits-1:0] tag_t; // Address bits 31 to 10.
	typedef logic [index_bits-1:0] index_t; // Address bits 9 to 4.
	typedef logic [word_sel_bits-1:0] word_sel_t; // Address bits 3 to 2.
	typedef logic [line_bytes*8-1:0] line_t; // Word 0 sits in the low bits.
	typedef logic [word_bytes*8-1:0] word_t;
	typedef logic [ways-1:0] way_mask_t;

	typedef enum logic [2:0] {
		idle,
		lookup,
		refill,
		refill_drop,
		respond
	} ctrl_state_t;

endpackage

// ==== source/icache_top.sv ====
`timescale 1ns/10ps

module icache_top (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input icache_pkg::addr_t fetch_addr,
	output logic fetch_ack,
	output icache_pkg::word_t inst,
	input logic flush,
	output logic mem_req,
	output icache_pkg::addr_t mem_addr,
	input logic mem_ack,
	input icache_pkg::line_t mem_line
);
	import icache_pkg::*;

	word_sel_t word_sel;
	logic refill_bypass;
	logic load_inst;

	way_bus_if way_bus[ways] (); // One bus per way.

	icache_ctrl ctrl_i (
		.clk (clk),
		.rst (rst),
		.fetch_req (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_ack (fetch_ack),
		.flush (flush),
		.mem_req (mem_req),
		.mem_addr (mem_addr),
		.mem_ack (mem_ack),
		.mem_line (mem_line),
		.word_sel (word_sel),
		.refill_bypass (refill_bypass),
		.load_inst (load_inst),
		.ports (way_bus)
	);

	for (genvar i = 0; i < ways; i++) begin : g_way
		icache_way way_i (
			.clk (clk),
			.rst (rst),
			.bus (way_bus[i])
		);
	end

	line_select select_i (
		.clk (clk),
		.rst (rst),
		.ports (way_bus),
		.mem_line (mem_line),
		.refill_bypass (refill_bypass),
		.word_sel (word_sel),
		.load_inst (load_inst),
		.inst (inst)
	);

endmodule

// ==== source/icache_way.sv ====
`timescale 1ns/10ps

module icache_way (
	input logic clk,
	input logic rst,
	way_bus_if.way bus
);
	import icache_pkg::*;

	tag_t tags[sets];
	line_t lines[sets];
	logic [sets-1:0] valid;

	assign bus.hit = valid[bus.index] && (tags[bus.index] == bus.tag);

	// Valid bits are the only state a flush has to touch.
	always_ff @(posedge clk) begin
		if (rst || bus.invalidate) begin
			valid <= '0;
		end else if (bus.fill) begin
			valid[bus.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.fill) begin
			tags[bus.index] <= bus.tag;
			lines[bus.index] <= bus.fill_line;
		end
	end

	// Read happens every cycle. A line written on this edge shows up one edge later.
	always_ff @(posedge clk) begin
		bus.rd_line <= lines[bus.index];
	end

endmodule

// ==== source/line_select.sv ====
`timescale 1ns/10ps

module line_select (
	input logic clk,
	input logic rst,
	way_bus_if.drain ports[icache_pkg::ways],
	input icache_pkg::line_t mem_line,
	input logic refill_bypass,
	input icache_pkg::word_sel_t word_sel,
	input logic load_inst,
	output icache_pkg::word_t inst
);
	import icache_pkg::*;

	way_mask_t hits;
	line_t way_lines[ways];
	line_t hit_line;
	line_t src_line;
	word_t word;

	for (genvar i = 0; i < ways; i++) begin : g_drain
		assign hits[i] = ports[i].hit;
		assign way_lines[i] = ports[i].rd_line;
	end

	// AND-OR mux. The hit vector is one-hot when it matters.
	always_comb begin
		hit_line = '0;
		for (int i = 0; i < ways; i++) begin
			if (hits[i]) begin
				hit_line = hit_line | way_lines[i];
			end
		end
	end

	assign src_line = refill_bypass ? mem_line : hit_line;
	assign word = src_line[word_sel * $bits(word_t) +: $bits(word_t)];

	always_ff @(posedge clk) begin
		if (rst) begin
			inst <= '0;
		end else if (load_inst) begin
			inst <= word; // Held until the next fetch loads it.
		end
	end

	a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
		(load_inst && !refill_bypass) |-> $onehot0(hits))
		else $error("hit vector not one-hot at load: %h", hits);

endmodule

// ==== source/way_bus_if.sv ====
`timescale 1ns/10ps

interface way_bus_if;
	import icache_pkg::*;

	index_t index;
	tag_t tag;
	logic fill; // Writes fill_line and tag at index.
	line_t fill_line;
	logic invalidate;
	logic hit;
	line_t rd_line; // Registered read of the line at index.

	modport ctrl (
		output index, tag, fill, fill_line, invalidate,
		input hit
	);

	modport way (
		input index, tag, fill, fill_line, invalidate,
		output hit, rd_line
	);

	modport drain (
		input hit, rd_line
	);

endinterface

// ==== verif/backing_mem.sv ====
`timescale 1ns/10ps

module backing_mem (
	input logic clk,
	input logic rst,
	input logic mem_req,
	input icache_pkg::addr_t mem_addr,
	output logic mem_ack,
	output icache_pkg::line_t mem_line
);
	import icache_pkg::*;

	integer seed;
	int unsigned wait_left;
	logic busy;

	// Word k of a line is the line address xor k, times the golden ratio constant.
	function automatic line_t line_at(addr_t line_addr);
		line_t line;
		for (int k = 0; k < 4; k++) begin
			line[k*32 +: 32] = (line_addr ^ addr_t'(k)) * 32'h9e3779b9;
		end
		return line;
	endfunction

	initial begin
		seed = 32'h1b21;
		mem_ack = 1'b0;
		mem_line = '0;
		busy = 1'b0;
		wait_left = 0;
	end

	always @(posedge clk) begin
		#1;
		if (rst) begin
			mem_ack = 1'b0;
			busy = 1'b0;
		end else if (mem_ack) begin
			if (!mem_req) begin
				mem_ack = 1'b0; // Last phase of the handshake.
			end
		end else if (busy) begin
			if (wait_left == 0) begin
				mem_line = line_at(mem_addr);
				mem_ack = 1'b1;
				busy = 1'b0;
			end else begin
				wait_left = wait_left - 1;
			end
		end else if (mem_req) begin
			busy = 1'b1;
			wait_left = $unsigned($random(seed)) % 6; // Random access latency.
		end
	end

endmodule

// ==== verif/tb_icache.sv ====
`timescale 1ns/10ps

module tb_icache;
	import icache_pkg::*;

	localparam int wait_limit = 200;

	logic clk;
	logic rst;
	logic fetch_req;
	addr_t fetch_addr;
	logic fetch_ack;
	word_t inst;
	logic flush;
	logic mem_req;
	addr_t mem_addr;
	logic mem_ack;
	line_t mem_line;

	integer seed;
	int error_count;
	int protocol_errors;
	int errors_at_start;
	int test_count;
	int failed_tests;
	logic timed_out;
	logic expect_hit; // The current fetch must hit.
	logic expect_miss;
	logic refill_seen;
	addr_t rand_addr;

	icache_top dut_i (
		.clk (clk),
		.rst (rst),
		.fetch_req (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_ack (fetch_ack),
		.inst (inst),
		.flush (flush),
		.mem_req (mem_req),
		.mem_addr (mem_addr),
		.mem_ack (mem_ack),
		.mem_line (mem_line)
	);

	backing_mem mem_i (
		.clk (clk),
		.rst (rst),
		.mem_req (mem_req),
		.mem_addr (mem_addr),
		.mem_ack (mem_ack),
		.mem_line (mem_line)
	);

	always #4 clk = ~clk;

	function automatic word_t mem_word(addr_t a);
		addr_t line_addr;
		line_addr = {a[31:4], 4'h0};
		return (line_addr ^ addr_t'(a[3:2])) * 32'h9e3779b9;
	endfunction

	// Every address lands in set 5 and carries a new tag for each n.
	function automatic addr_t same_set_addr(int n);
		return 32'h0004_0050 + n * 32'h400;
	endfunction

	a_reset_idle: assert property (@(posedge clk) rst |=> !mem_req && !fetch_ack)
		else begin
			$display("Reset left mem_req or fetch_ack high");
			protocol_errors++;
			error_count++;
		end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(fetch_ack) |-> $past(fetch_req))
		else begin
			$display("fetch_ack rose while fetch_req was low");
			protocol_errors++;
			error_count++;
		end

	a_inst_stable: assert property (@(posedge clk) disable iff (rst)
		fetch_ack |=> !fetch_ack || $stable(inst))
		else begin
			$display("inst changed while fetch_ack was high");
			protocol_errors++;
			error_count++;
		end

	a_ack_held: assert property (@(posedge clk) disable iff (rst)
		fetch_ack && fetch_req |=> fetch_ack)
		else begin
			$display("fetch_ack fell while fetch_req was still held");
			protocol_errors++;
			error_count++;
		end

	a_inst_value: assert property (@(posedge clk) disable iff (rst)
		fetch_ack |-> inst == mem_word(fetch_addr))
		else begin
			$display("Mismatch inst: got %h, expected %h", inst, mem_word(fetch_addr));
			error_count++;
		end

	a_refill_addr: assert property (@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> mem_addr == {fetch_addr[31:4], 4'h0})
		else begin
			$display("Mismatch mem_addr: got %h, expected %h", mem_addr,
				{fetch_addr[31:4], 4'h0});
			error_count++;
		end

	a_hit_no_refill: assert property (@(posedge clk) disable iff (rst)
		fetch_req && expect_hit |-> !mem_req)
		else begin
			$display("mem_req rose on a fetch that should hit");
			error_count++;
		end

	// The DUT drives fetch_ack on the second edge after the one that took fetch_req,
	// so the sampled value shows it on the third.
	a_hit_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(fetch_ack) && expect_hit |-> $past(fetch_req, 3) && !$past(fetch_req, 4))
		else begin
			$display("fetch_ack on a hit did not come two cycles after fetch_req");
			error_count++;
		end

	a_miss_refill: assert property (@(posedge clk) disable iff (rst)
		$rose(fetch_ack) && expect_miss |-> refill_seen)
		else begin
			$display("A fetch that should miss finished without a refill");
			error_count++;
		end

	task automatic report_timeout(input string what);
		$display("Timeout: %s for address %h", what, fetch_addr);
		timed_out = 1'b1;
		error_count++;
	endtask

	task automatic fetch_word(input addr_t addr, input logic want_hit, input logic want_miss);
		int cycles;
		int hold;
		if (timed_out) begin
			return;
		end
		expect_hit = want_hit;
		expect_miss = want_miss;
		refill_seen = 1'b0;
		fetch_addr = addr;
		fetch_req = 1'b1;
		cycles = 0;
		while (!fetch_ack && !timed_out) begin
			@(posedge clk);
			#1;
			cycles++;
			if (mem_req) begin
				refill_seen = 1'b1;
			end
			if (cycles > wait_limit) begin
				report_timeout("fetch_ack did not rise");
			end
		end
		hold = $unsigned($random(seed)) % 4; // Back-pressure from the requester.
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		fetch_req = 1'b0;
		cycles = 0;
		while (fetch_ack && !timed_out) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > wait_limit) begin
				report_timeout("fetch_ack did not fall");
			end
		end
		expect_hit = 1'b0;
		expect_miss = 1'b0;
	endtask

	// Only valid while the DUT is idle.
	task automatic pulse_flush();
		if (timed_out) begin
			return;
		end
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic close_test(input string name);
		test_count++;
		if (error_count == errors_at_start) begin
			$display("Test %0d, %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("Test %0d, %s: failed with %0d errors", test_count, name,
				error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		flush = 1'b0;
		seed = 32'h1b21;
		error_count = 0;
		protocol_errors = 0;
		errors_at_start = 0;
		test_count = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		expect_hit = 1'b0;
		expect_miss = 1'b0;
		refill_seen = 1'b0;
		repeat (3) begin
			@(posedge clk);
		end
		#1;
		rst = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
		end
		close_test("reset");

		fetch_word(32'h0000_2468, 1'b0, 1'b1);
		close_test("first fetch misses");

		fetch_word(32'h0000_2460, 1'b1, 1'b0);
		fetch_word(32'h0000_246c, 1'b1, 1'b0);
		fetch_word(32'h0000_2468, 1'b1, 1'b0);
		close_test("same line hits");

		// Five fills in a row land in rotating ways, so the fifth replaces the first.
		for (int n = 0; n < 5; n++) begin
			fetch_word(same_set_addr(n), 1'b0, 1'b1);
		end
		fetch_word(same_set_addr(0) + 4, 1'b0, 1'b1);
		fetch_word(same_set_addr(2) + 8, 1'b1, 1'b0);
		close_test("victim rotation in one set");

		pulse_flush();
		fetch_word(32'h0000_2464, 1'b0, 1'b1);
		close_test("flush");

		for (int n = 0; n < 200; n++) begin
			rand_addr = 32'h0001_0000 | ($unsigned($random(seed)) & 32'h0000_0ffc);
			fetch_word(rand_addr, 1'b0, 1'b0);
		end
		close_test("random fetches");

		test_count++;
		if (protocol_errors == 0) begin
			$display("Test %0d, protocol checks over the run: ok", test_count);
		end else begin
			failed_tests++;
			$display("Test %0d, protocol checks over the run: failed with %0d errors",
				test_count, protocol_errors);
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0 && !timed_out) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
source/icache_pkg.sv
source/way_bus_if.sv
source/icache_ctrl.sv
source/icache_way.sv
source/line_select.sv
source/icache_top.sv
verif/backing_mem.sv
verif/tb_icache.sv
